//--- i8008_pkg.sv
`default_nettype none

package i8008_pkg;

  typedef logic [7:0]  byte_t;    // Data bus, registers and ALU values
  typedef logic [13:0] addr_t;    // Memory address
  typedef logic [2:0]  reg_sel_t; // Register index as encoded in opcodes
  typedef logic [3:0]  flags_t;

  // Register indices follow the DDD/SSS opcode fields
  localparam reg_sel_t REG_A = 3'd0;
  localparam reg_sel_t REG_B = 3'd1;
  localparam reg_sel_t REG_C = 3'd2;
  localparam reg_sel_t REG_D = 3'd3;
  localparam reg_sel_t REG_E = 3'd4;
  localparam reg_sel_t REG_H = 3'd5;
  localparam reg_sel_t REG_L = 3'd6;
  localparam reg_sel_t REG_M = 3'd7; // Memory at H:L
  localparam int NUM_REGS = 7;

  localparam int FLAG_CARRY  = 0;
  localparam int FLAG_ZERO   = 1;
  localparam int FLAG_SIGN   = 2;
  localparam int FLAG_PARITY = 3;

  // Codes as seen on the S2..S0 state pins
  typedef enum logic [2:0] {
    T1      = 3'b010,
    T2      = 3'b001,
    T3      = 3'b100,
    T4      = 3'b111,
    T5      = 3'b101,
    WAIT    = 3'b000,
    STOPPED = 3'b110
  } t_state_t;

  // Cycle type driven on D7:D6 during T2
  typedef enum logic [1:0] {
    PCI = 2'b00, // Instruction fetch
    PCR = 2'b10, // Memory read
    PCW = 2'b11  // Memory write
  } cycle_t;

  // Low eight codes match the PPP field of ALU opcodes
  typedef enum logic [3:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB,
    ALU_AND, ALU_XOR, ALU_OR,  ALU_CMP,
    ALU_INC, ALU_DEC,
    ALU_RLC, ALU_RRC, ALU_RAL, ALU_RAR
  } alu_fn_t;

  localparam byte_t OP_HLT0 = 8'h00;
  localparam byte_t OP_HLT1 = 8'h01;
  localparam byte_t OP_HLT2 = 8'hFF;

  // Opcode groups in bits 7:6
  localparam logic [1:0] GRP_IMM = 2'b00; // Immediates, INr/DCr, rotates
  localparam logic [1:0] GRP_ALU = 2'b10; // ALUr
  localparam logic [1:0] GRP_MOV = 2'b11; // Lr1r2, LMr

  // Bits 2:0 within the 00 group
  localparam logic [2:0] LOW_INR  = 3'b000;
  localparam logic [2:0] LOW_DCR  = 3'b001;
  localparam logic [2:0] LOW_ROT  = 3'b010;
  localparam logic [2:0] LOW_ALUI = 3'b100;
  localparam logic [2:0] LOW_LRI  = 3'b110;

endpackage

`default_nettype wire

//--- t_state_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module t_state_sequencer import i8008_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  byte_t    data_in,
  input  logic     ready,
  output t_state_t state,
  output cycle_t   cycle,
  output logic     sync,
  output reg_sel_t src_sel,
  output reg_sel_t wr_sel,
  output logic     rf_we,
  output logic     wb_from_alu,
  output alu_fn_t  alu_fn,
  output logic     flags_we,
  output logic     operand_from_rf
);

  byte_t    ir;
  reg_sel_t ddd, sss;
  t_state_t next_state;
  cycle_t   next_cycle;
  logic     xfer; // Data taken in T3 or in the WAIT that ends it
  logic     is_mov, is_lmr, is_alur, is_alui, is_lri, is_inr, is_dcr, is_rot;

  function automatic logic is_halt(byte_t op);
    return (op == OP_HLT0) || (op == OP_HLT1) || (op == OP_HLT2);
  endfunction

  // LrI and ALUI fetch a second byte
  function automatic logic needs_pcr(byte_t op);
    return (op[7:6] == GRP_IMM) &&
           ((op[2:0] == LOW_ALUI) || ((op[2:0] == LOW_LRI) && (op[5:3] != REG_M)));
  endfunction

  assign ddd  = ir[5:3];
  assign sss  = ir[2:0];
  assign xfer = ready && ((state == T3) || (state == WAIT));
  assign sync = (state == T1);

  assign is_mov  = (ir[7:6] == GRP_MOV) && (ddd != REG_M) && (sss != REG_M);
  assign is_lmr  = (ir[7:6] == GRP_MOV) && (ddd == REG_M) && (sss != REG_M);
  assign is_alur = (ir[7:6] == GRP_ALU) && (sss != REG_M);
  assign is_alui = (ir[7:6] == GRP_IMM) && (sss == LOW_ALUI);
  assign is_lri  = (ir[7:6] == GRP_IMM) && (sss == LOW_LRI) && (ddd != REG_M);
  assign is_inr  = (ir[7:6] == GRP_IMM) && (sss == LOW_INR) && (ddd != REG_A) && (ddd != REG_M);
  assign is_dcr  = (ir[7:6] == GRP_IMM) && (sss == LOW_DCR) && (ddd != REG_A) && (ddd != REG_M);
  assign is_rot  = (ir[7:6] == GRP_IMM) && (sss == LOW_ROT) && !ddd[2];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T1;
      cycle <= PCI;
      ir    <= '0;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
      if (xfer && (cycle == PCI)) begin
        ir <= data_in; // Opcode byte
      end
    end
  end

  always_comb begin
    next_state = state; // STOPPED holds until reset
    next_cycle = cycle;
    case (state)
      T1: next_state = T2;
      T2: next_state = T3;
      T3, WAIT: begin
        if (!ready) begin
          next_state = WAIT;
        end else if (cycle == PCI) begin
          // Decode straight off the bus, IR loads at this edge
          if (is_halt(data_in)) begin
            next_state = STOPPED;
          end else if (needs_pcr(data_in)) begin
            next_state = T1;
            next_cycle = PCR;
          end else begin
            next_state = T4;
          end
        end else if (cycle == PCR) begin
          next_state = T4;
        end else begin
          next_state = T1; // End of PCW
          next_cycle = PCI;
        end
      end
      T4: begin
        if ((cycle == PCI) && is_lmr) begin
          next_state = T1;
          next_cycle = PCW;
        end else begin
          next_state = T5;
        end
      end
      T5: begin
        next_state = T1;
        next_cycle = PCI;
      end
      default: ;
    endcase
  end

  always_comb begin
    src_sel         = REG_A;
    wr_sel          = REG_A;
    rf_we           = 1'b0;
    wb_from_alu     = 1'b0;
    flags_we        = 1'b0;
    operand_from_rf = 1'b0;

    if (is_inr) begin
      alu_fn = ALU_INC;
    end else if (is_dcr) begin
      alu_fn = ALU_DEC;
    end else if (is_rot) begin
      case (ddd[1:0])
        2'b00:   alu_fn = ALU_RLC;
        2'b01:   alu_fn = ALU_RRC;
        2'b10:   alu_fn = ALU_RAL;
        default: alu_fn = ALU_RAR;
      endcase
    end else begin
      alu_fn = alu_fn_t'({1'b0, ddd}); // PPP field
    end

    // Register operand read into the latch
    if ((state == T4) && (cycle == PCI)) begin
      operand_from_rf = 1'b1;
      if (is_inr || is_dcr) begin
        src_sel = ddd;
      end else if (!is_rot) begin
        src_sel = sss;
      end
    end

    if (state == T5) begin
      if (is_mov || is_lri) begin
        rf_we  = 1'b1;
        wr_sel = ddd;
      end else if (is_alur || is_alui) begin
        rf_we       = (alu_fn != ALU_CMP); // CMP only sets flags
        wb_from_alu = 1'b1;
        flags_we    = 1'b1;
      end else if (is_inr || is_dcr || is_rot) begin
        rf_we       = 1'b1;
        wr_sel      = is_rot ? REG_A : ddd;
        wb_from_alu = 1'b1;
        flags_we    = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import i8008_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_sel_t src_sel,
  input  reg_sel_t wr_sel,
  input  logic     we,
  input  byte_t    wr_data,
  input  byte_t    alu_result,
  input  logic     wb_from_alu,
  output byte_t    src_data,
  output byte_t    acc,
  output byte_t    h,
  output byte_t    l
);

  byte_t regs [NUM_REGS];
  byte_t wb_data;

  assign wb_data = wb_from_alu ? alu_result : wr_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wr_sel != REG_M)) begin
      regs[wr_sel] <= wb_data;
    end
  end

  assign src_data = (src_sel == REG_M) ? '0 : regs[src_sel]; // M has no storage here
  assign acc      = regs[REG_A];
  assign h        = regs[REG_H]; // Store address high
  assign l        = regs[REG_L];

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import i8008_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  byte_t   acc,
  input  byte_t   operand,
  input  alu_fn_t fn,
  input  logic    flags_we,
  output byte_t   result
);

  flags_t flags, flags_next;
  logic   carry_in, carry_out;
  logic   is_rotate;

  assign carry_in  = flags[FLAG_CARRY];
  assign is_rotate = (fn == ALU_RLC) || (fn == ALU_RRC) || (fn == ALU_RAL) || (fn == ALU_RAR);

  always_comb begin
    carry_out = 1'b0; // Logic ops clear carry
    result    = '0;
    case (fn)
      ALU_ADD: {carry_out, result} = {1'b0, acc} + {1'b0, operand};
      ALU_ADC: {carry_out, result} = {1'b0, acc} + {1'b0, operand} + {8'd0, carry_in};
      // Bit 8 of the difference is the borrow
      ALU_SUB, ALU_CMP: {carry_out, result} = {1'b0, acc} - {1'b0, operand};
      ALU_SBB: {carry_out, result} = {1'b0, acc} - {1'b0, operand} - {8'd0, carry_in};
      ALU_AND: result = acc & operand;
      ALU_XOR: result = acc ^ operand;
      ALU_OR:  result = acc | operand;
      ALU_INC: begin
        result    = operand + 8'd1;
        carry_out = carry_in; // Carry untouched
      end
      ALU_DEC: begin
        result    = operand - 8'd1;
        carry_out = carry_in;
      end
      ALU_RLC: begin
        result    = {acc[6:0], acc[7]};
        carry_out = acc[7];
      end
      ALU_RRC: begin
        result    = {acc[0], acc[7:1]};
        carry_out = acc[0];
      end
      ALU_RAL: begin
        result    = {acc[6:0], carry_in}; // Rotate through carry
        carry_out = acc[7];
      end
      ALU_RAR: begin
        result    = {carry_in, acc[7:1]};
        carry_out = acc[0];
      end
      default: carry_out = carry_in;
    endcase
  end

  always_comb begin
    flags_next             = flags;
    flags_next[FLAG_CARRY] = carry_out;
    if (!is_rotate) begin
      flags_next[FLAG_ZERO]   = (result == 8'd0);
      flags_next[FLAG_SIGN]   = result[7];
      flags_next[FLAG_PARITY] = ~^result; // Even number of ones
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flags_we) begin
      flags <= flags_next;
    end
  end

endmodule

`default_nettype wire

//--- bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bus_unit import i8008_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  t_state_t state,
  input  cycle_t   cycle,
  input  logic     ready,
  input  byte_t    data_in,
  input  byte_t    src_data,
  input  byte_t    h,
  input  byte_t    l,
  input  logic     operand_from_rf,
  output byte_t    operand,
  output byte_t    data_out
);

  addr_t pc;
  addr_t addr;
  logic  rd_xfer;

  // Read cycles complete in T3, or in the WAIT that stands in for it
  assign rd_xfer = ready && ((state == T3) || (state == WAIT)) &&
                   ((cycle == PCI) || (cycle == PCR));

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (rd_xfer) begin
      pc <= pc + 14'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_xfer && (cycle == PCR)) begin
      operand <= data_in; // Immediate byte
    end else if (operand_from_rf) begin
      operand <= src_data;
    end
  end

  assign addr = (cycle == PCW) ? {h[5:0], l} : pc;

  always_comb begin
    case (state)
      T1:      data_out = addr[7:0];
      T2:      data_out = {cycle, addr[13:8]};
      T3, WAIT: data_out = (cycle == PCW) ? operand : '0; // Store data held while waiting
      default: data_out = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- i8008_core.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_core import i8008_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  byte_t    data_in,
  input  logic     ready,
  output byte_t    data_out,
  output logic     sync,
  output t_state_t state
);

  cycle_t   cycle;
  reg_sel_t src_sel, wr_sel;
  logic     rf_we, wb_from_alu;
  alu_fn_t  alu_fn;
  logic     flags_we, operand_from_rf;
  byte_t    src_data, acc, h, l;
  byte_t    alu_result, operand;

  t_state_sequencer seq_i (
    .clk, .rst, .data_in, .ready,
    .state, .cycle, .sync,
    .src_sel, .wr_sel, .rf_we, .wb_from_alu,
    .alu_fn, .flags_we, .operand_from_rf
  );

  reg_file rf_i (
    .clk, .rst, .src_sel, .wr_sel,
    .we(rf_we), .wr_data(operand), .alu_result, .wb_from_alu,
    .src_data, .acc, .h, .l
  );

  alu alu_i (
    .clk, .rst, .acc, .operand,
    .fn(alu_fn), .flags_we, .result(alu_result)
  );

  bus_unit bus_i (
    .clk, .rst, .state, .cycle, .ready,
    .data_in, .src_data, .h, .l,
    .operand_from_rf, .operand, .data_out
  );

endmodule

`default_nettype wire

//--- i8008_sva.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_sva import i8008_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     ready,
  input logic     sync,
  input t_state_t state
);

  int failures;

  initial begin
    failures = 0;
  end

  // SYNC marks the first state of every bus cycle
  sync_in_t1: assert property (@(posedge clk) disable iff (rst) sync == (state == T1))
    else begin
      $error("sync does not match T1");
      failures++;
    end

  t1_then_t2: assert property (@(posedge clk) disable iff (rst) (state == T1) |=> (state == T2))
    else begin
      $error("T1 not followed by T2");
      failures++;
    end

  wait_holds: assert property (@(posedge clk) disable iff (rst)
    (state == WAIT && !ready) |=> (state == WAIT))
    else begin
      $error("WAIT left while ready low");
      failures++;
    end

  wait_ends: assert property (@(posedge clk) disable iff (rst)
    (state == WAIT && ready) |=> (state != WAIT))
    else begin
      $error("WAIT kept while ready high");
      failures++;
    end

  // Only reset leaves the halt state
  stopped_holds: assert property (@(posedge clk) disable iff (rst)
    (state == STOPPED) |=> (state == STOPPED))
    else begin
      $error("STOPPED left without reset");
      failures++;
    end

endmodule

bind i8008_core i8008_sva i8008_sva_i (.clk, .rst, .ready, .sync, .state);

`default_nettype wire

//--- i8008_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_tb import i8008_pkg::*; ();

  localparam int PROG_INSTR = 60; // Random instructions before the final HLT
  localparam int HALT_HOLD  = 20; // Clocks watched after STOPPED

  logic     clk, rst, ready, sync;
  byte_t    data_in, data_out;
  t_state_t state;

  byte_t       mem [16384];
  int          prog_len;
  logic [15:0] lfsr;
  logic        random_ready;

  // Reference model state
  byte_t m_regs [NUM_REGS];
  logic  m_carry, m_zero, m_sign, m_parity;
  addr_t m_pc;

  logic [15:0] bus_q [$]; // Expected bus cycles as {cycle code, address}
  logic [15:0] cur;
  addr_t       pc0, st_addr, fetch_addr;
  byte_t       fetch_lo, exp_data;
  t_state_t    last_state;
  logic        exp_halt, imm, st, in_instr, halted, timed_out;
  int          exp_clocks, instr_clocks, instr_waits;
  int          n_instr, n_waits, test_errors, total_errors, tests_run, tests_failed;

  i8008_core i8008_core_i (.clk, .rst, .data_in, .ready, .data_out, .sync, .state);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  function automatic byte_t take_bits(input int n);
    byte_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic reg_sel_t pick_reg();
    byte_t v;
    v = take_bits(3);
    return (v[2:0] == REG_M) ? REG_A : v[2:0];
  endfunction

  task automatic put_byte(input byte_t b);
    mem[prog_len] = b;
    prog_len++;
  endtask

  task automatic build_program();
    byte_t    kind, r;
    reg_sel_t d, s, follow;
    for (int a = 0; a < 16384; a++) begin
      mem[a] = a[7:0] ^ a[13:6];
    end
    prog_len = 0;
    put_byte({2'b11, REG_M, REG_B}); // LMB to address 0, reads zero after any reset
    repeat (PROG_INSTR) begin
      kind   = take_bits(3);
      d      = pick_reg();
      s      = pick_reg();
      follow = REG_A; // Each result is stored right after it is made
      case (kind[2:0])
        3'd0: begin
          put_byte({2'b11, d, s}); // Lr1r2
          follow = d;
        end
        3'd1: begin
          put_byte({2'b00, d, 3'b110}); // LrI
          put_byte(take_bits(8));
          follow = d;
        end
        3'd2, 3'd3: begin
          r = take_bits(3);
          put_byte({2'b10, r[2:0], s});
        end
        3'd4: begin
          r = take_bits(3);
          put_byte({2'b00, r[2:0], 3'b100}); // ALUI
          put_byte(take_bits(8));
        end
        3'd5: begin
          r = take_bits(1);
          if (d == REG_A) begin
            d = REG_B; // INA and DCA encode as HLT
          end
          put_byte({2'b00, d, 2'b00, r[0]});
          follow = d;
        end
        3'd6: begin
          r = take_bits(2);
          put_byte({3'b000, r[1:0], 3'b010}); // RLC, RRC, RAL, RAR
        end
        default: put_byte({2'b11, REG_M, s});
      endcase
      if (kind[2:0] != 3'd7) begin
        put_byte({2'b11, REG_M, follow});
      end
    end
    r = take_bits(2);
    put_byte((r[1:0] == 2'd0) ? OP_HLT0 : (r[1:0] == 2'd1) ? OP_HLT1 : OP_HLT2);
  endtask

  task automatic model_reset();
    for (int i = 0; i < NUM_REGS; i++) begin
      m_regs[i] = '0;
    end
    m_carry  = 1'b0;
    m_zero   = 1'b0;
    m_sign   = 1'b0;
    m_parity = 1'b0;
    m_pc     = '0;
  endtask

  function automatic void set_zsp(input byte_t r);
    m_zero   = (r == 8'd0);
    m_sign   = r[7];
    m_parity = (($countones(r) % 2) == 0); // Even number of ones
  endfunction

  function automatic flags_t model_flags();
    flags_t f;
    f              = '0;
    f[FLAG_CARRY]  = m_carry;
    f[FLAG_ZERO]   = m_zero;
    f[FLAG_SIGN]   = m_sign;
    f[FLAG_PARITY] = m_parity;
    return f;
  endfunction

  function automatic void ref_alu(input logic [2:0] fn, input int b);
    int a, r;
    a = m_regs[REG_A];
    case (fn)
      3'd0:       r = a + b;
      3'd1:       r = a + b + m_carry;
      3'd2, 3'd7: r = a - b;
      3'd3:       r = a - b - m_carry;
      3'd4:       r = a & b;
      3'd5:       r = a ^ b;
      default:    r = a | b;
    endcase
    // Carry out of bit 7 on adds, borrow on subtracts, cleared by logic ops
    m_carry = (fn <= 3'd1) ? (r > 255) : (fn <= 3'd3 || fn == 3'd7) ? (r < 0) : 1'b0;
    set_zsp(r[7:0]);
    if (fn != 3'd7) begin
      m_regs[REG_A] = r[7:0];
    end
  endfunction

  // Runs one instruction on the model, returns its clocks without WAIT
  function automatic int ref_exec(output logic halt, output logic has_imm,
                                  output logic store, output addr_t addr, output byte_t data);
    byte_t    op, a;
    reg_sel_t d, s;
    logic     c, fill;
    op      = mem[m_pc];
    d       = op[5:3];
    s       = op[2:0];
    m_pc    = m_pc + 14'd1;
    halt    = 1'b0;
    has_imm = 1'b0;
    store   = 1'b0;
    addr    = '0;
    data    = '0;
    if (op == OP_HLT0 || op == OP_HLT1 || op == OP_HLT2) begin
      halt = 1'b1;
      return 3;
    end
    if (op[7:6] == 2'b11 && d == REG_M) begin
      store = 1'b1;
      addr  = {m_regs[REG_H][5:0], m_regs[REG_L]};
      data  = m_regs[s];
      return 7;
    end else if (op[7:6] == 2'b11) begin
      m_regs[d] = m_regs[s];
    end else if (op[7:6] == 2'b10) begin
      ref_alu(d, m_regs[s]);
    end else if (op[7:6] == 2'b00 && (s == 3'b110 || s == 3'b100)) begin
      has_imm = 1'b1;
      if (s == 3'b110) begin
        m_regs[d] = mem[m_pc];
      end else begin
        ref_alu(d, mem[m_pc]);
      end
      m_pc = m_pc + 14'd1;
      return 8;
    end else if (op[7:6] == 2'b00 && s == 3'b000) begin
      m_regs[d] = m_regs[d] + 8'd1;
      set_zsp(m_regs[d]);
    end else if (op[7:6] == 2'b00 && s == 3'b001) begin
      m_regs[d] = m_regs[d] - 8'd1;
      set_zsp(m_regs[d]);
    end else if (op[7:6] == 2'b00 && s == 3'b010) begin
      a    = m_regs[REG_A];
      c    = d[0] ? a[0] : a[7];  // Bit shifted out
      fill = d[1] ? m_carry : c;  // RAL and RAR rotate through carry
      m_regs[REG_A] = d[0] ? {fill, a[7:1]} : {a[6:0], fill};
      m_carry = c;
    end
    return 5;
  endfunction

  task automatic report_mismatch(input string what, input int got, input int exp);
    $display("Mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
    test_errors++;
  endtask

  // Memory model and READY, driven on the rising edge
  always @(posedge clk) begin
    if (last_state == T2) begin
      data_in <= mem[fetch_addr]; // Held through T3 and WAIT
    end
    if (random_ready) begin
      ready <= (take_bits(2) != 8'd0);
    end else begin
      ready <= 1'b1;
    end
  end

  // Bus checker, samples mid-cycle
  always @(negedge clk) begin
    last_state = state;
    if (state == T1) begin
      fetch_lo = data_out;
    end
    if (state == T2) begin
      fetch_addr = {data_out[5:0], fetch_lo};
    end
    if (rst) begin
      model_reset();
      bus_q.delete();
      in_instr = 1'b0;
      halted   = 1'b0;
    end else if (halted) begin
      if (state !== STOPPED || sync !== 1'b0) begin
        $display("Error at %0d ns: core left STOPPED or raised sync after HLT", $time);
        test_errors++;
      end
    end else begin
      instr_clocks++;
      case (state)
        T1: begin
          if (bus_q.size() == 0) begin
            if (in_instr && instr_clocks - 1 != exp_clocks + instr_waits) begin
              report_mismatch("instruction clocks", instr_clocks - 1, exp_clocks + instr_waits);
            end
            if (in_instr && i8008_core_i.alu_i.flags !== model_flags()) begin
              report_mismatch("flags", i8008_core_i.alu_i.flags, model_flags());
            end
            pc0        = m_pc;
            exp_clocks = ref_exec(exp_halt, imm, st, st_addr, exp_data);
            bus_q.push_back({PCI, pc0});
            if (imm) begin
              bus_q.push_back({PCR, pc0 + 14'd1});
            end
            if (st) begin
              bus_q.push_back({PCW, st_addr});
            end
            instr_clocks = 1;
            instr_waits  = 0;
            in_instr     = 1'b1;
            n_instr++;
          end
          cur = bus_q.pop_front();
          if (data_out !== cur[7:0]) begin
            report_mismatch("T1 address low", data_out, cur[7:0]);
          end
        end
        T2: begin
          if (data_out !== {cur[15:14], cur[13:8]}) begin
            report_mismatch("T2 cycle and address high", data_out, {cur[15:14], cur[13:8]});
          end
        end
        T3, WAIT: begin
          if (!ready) begin
            instr_waits++; // Next clock must be a WAIT
            n_waits++;
          end
          if (data_out !== ((cur[15:14] == PCW) ? exp_data : 8'h00)) begin
            report_mismatch("T3 data", data_out, (cur[15:14] == PCW) ? exp_data : 8'h00);
          end
        end
        STOPPED: begin
          if (!exp_halt) begin
            $display("Error at %0d ns: core stopped on an instruction that is not HLT", $time);
            test_errors++;
          end else if (instr_clocks - 1 != exp_clocks + instr_waits) begin
            report_mismatch("HLT clocks", instr_clocks - 1, exp_clocks + instr_waits);
          end
          halted = 1'b1;
        end
        default: begin
          if (data_out !== 8'h00) begin
            report_mismatch("idle bus", data_out, 0);
          end
        end
      endcase
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_test(input string name, input logic with_waits, input logic mid_reset);
    int clocks, limit;
    limit        = prog_len * 8 + prog_len * 2 * 3 + 200; // Up to two bus cycles per byte
    clocks       = 0;
    test_errors  = 0;
    n_instr      = 0;
    n_waits      = 0;
    random_ready = with_waits;
    apply_reset();
    if (mid_reset) begin
      repeat (60) @(posedge clk);
      apply_reset(); // Fetch restarts at 0, first LMB must store zero
    end
    while (!halted && clocks < limit) begin
      @(posedge clk);
      clocks++;
    end
    tests_run++;
    total_errors += test_errors;
    if (!halted) begin
      $display("Timeout: test %s did not reach HLT within %0d clocks", name, limit);
      timed_out = 1'b1;
      tests_failed++;
    end else begin
      repeat (HALT_HOLD) @(posedge clk);
      $display("Test %s: %0d instructions, %0d WAIT clocks, %0d errors",
               name, n_instr, n_waits, test_errors);
      if (test_errors != 0) begin
        tests_failed++;
      end
    end
  endtask

  initial begin
    rst          = 1'b1;
    ready        = 1'b1;
    data_in      = '0;
    random_ready = 1'b0;
    halted       = 1'b0;
    in_instr     = 1'b0;
    timed_out    = 1'b0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr         = 16'd61941;
    build_program();
    run_test("ready high", 1'b0, 1'b0);
    if (!timed_out) begin
      run_test("random WAIT states", 1'b1, 1'b0);
    end
    if (!timed_out) begin
      run_test("reset in mid-program", 1'b1, 1'b1);
    end
    $display("Summary: %0d tests, %0d with errors, %0d errors in total, %0d assertion failures",
             tests_run, tests_failed, total_errors, i8008_core_i.i8008_sva_i.failures);
    if (tests_failed == 0 && i8008_core_i.i8008_sva_i.failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
i8008_pkg.sv
t_state_sequencer.sv
reg_file.sv
alu.sv
bus_unit.sv
i8008_core.sv
i8008_sva.sv
i8008_tb.sv
